//--- rtl/uart_params.svh
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// clock cycles per bit on both tx and rx.
// keep it even so that half a period is a whole number of cycles.
`define UART_CLKS_PER_BIT 8

// start, eight data bits, parity and stop.
`define UART_FRAME_BITS 11

// set to 0 to force the received parity error flag low.
`define UART_PARITY_CHECK 1

`endif

//--- rtl/uart_pkg.sv
`include "uart_params.svh"

package uart_pkg;

  typedef logic [7:0] uart_byte_t;

  typedef logic [15:0] uart_cmd_t;  // high byte goes out first.

  // parity error flag in bit 8, received byte below it.
  typedef logic [8:0] uart_read_t;

  typedef logic [3:0] bit_cnt_t;  // bit index within one frame.

  typedef logic [$clog2(`UART_CLKS_PER_BIT)-1:0] tick_cnt_t;

  typedef enum logic [1:0] {
    IDLE,
    SEND_HI,
    SEND_LO
  } ctrl_state_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_BITS,
    RX_STOP
  } rx_state_t;

endpackage

//--- rtl/uart_tx_if.sv
interface uart_tx_if
  import uart_pkg::*;
();

  logic       load;  // one cycle, only while busy is low.
  uart_byte_t data;  // taken by the shifter in the load cycle.
  logic       busy;
  logic       done;  // one cycle after the stop bit has been held.

  modport ctrl (
    output load,
    output data,
    input  busy,
    input  done
  );

  modport shifter (
    input  load,
    input  data,
    output busy,
    output done
  );

endinterface

//--- rtl/baud_timer.sv
`include "uart_params.svh"

module baud_timer
  import uart_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  input  logic half,
  output logic tick
);

  localparam tick_cnt_t LAST = tick_cnt_t'(`UART_CLKS_PER_BIT - 1);

  // preloaded on the rising edge of run so the first tick falls at mid-bit.
  localparam tick_cnt_t HALF_START = tick_cnt_t'(`UART_CLKS_PER_BIT / 2 + 1);

  tick_cnt_t cnt;
  logic      run_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt   <= '0;
      run_q <= 1'b0;
    end else begin
      run_q <= run;
      if (!run) begin
        cnt <= '0;
      end else if (tick) begin
        cnt <= '0;
      end else if (!run_q && half) begin
        cnt <= HALF_START;
      end else begin
        cnt <= cnt + tick_cnt_t'(1);
      end
    end
  end

  assign tick = (cnt == LAST);

  // run may only drop on a tick, otherwise a stale count could still tick.
  a_no_tick_when_stopped: assert property (
    @(posedge clk) disable iff (!rst_n) !run |-> !tick
  );

endmodule

//--- rtl/uart_tx_shifter.sv
`include "uart_params.svh"

module uart_tx_shifter
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  uart_tx_if.shifter txi,
  input  logic       tick,
  output logic       timer_run,
  output logic       tx
);

  localparam bit_cnt_t STOP_IDX = bit_cnt_t'(`UART_FRAME_BITS - 1);

  logic [`UART_FRAME_BITS-1:0] frame_q;  // bit 0 is the one on the line.
  bit_cnt_t                    bit_cnt;
  logic                        last_bit;

  assign last_bit = (bit_cnt == STOP_IDX);

  // stop, odd parity, data LSB first, start.
  always_ff @(posedge clk) begin
    if (txi.load) begin
      frame_q <= {1'b1, ~^txi.data, txi.data, 1'b0};
    end else if (tick) begin
      frame_q <= {1'b1, frame_q[`UART_FRAME_BITS-1:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      txi.busy <= 1'b0;
      txi.done <= 1'b0;
      tx       <= 1'b1;
      bit_cnt  <= '0;
    end else begin
      txi.done <= 1'b0;
      if (txi.load) begin
        txi.busy <= 1'b1;
        tx       <= 1'b0;  // start bit.
        bit_cnt  <= '0;
      end else if (tick) begin
        if (last_bit) begin
          txi.busy <= 1'b0;
          txi.done <= 1'b1;
          tx       <= 1'b1;
        end else begin
          tx      <= frame_q[1];
          bit_cnt <= bit_cnt + bit_cnt_t'(1);
        end
      end
    end
  end

  // the bit timer runs for exactly the frame.
  assign timer_run = txi.busy;

  a_load_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n) txi.load |-> !txi.busy
  );

endmodule

//--- rtl/uart_rx_sampler.sv
`include "uart_params.svh"

module uart_rx_sampler
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       tick,
  output logic       timer_run,
  output logic       timer_half,
  output logic       read_rdy,
  output uart_read_t read_data
);

  // index of the parity bit among the bits after start.
  localparam bit_cnt_t PARITY_IDX = bit_cnt_t'(`UART_FRAME_BITS - 3);

  logic       rx_meta;
  logic       rx_sync;
  logic       rx_prev;
  rx_state_t  state;
  bit_cnt_t   bit_cnt;
  logic [8:0] shift_q;  // parity bit ends up on top.
  logic       parity_err;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign timer_run  = (state != RX_IDLE);
  assign timer_half = (state == RX_START);  // only seen when the timer starts.

  // data and parity together must hold an odd number of ones.
  assign parity_err = (`UART_PARITY_CHECK != 0) && !(^shift_q);

  always_ff @(posedge clk) begin
    if (state == RX_BITS && tick) begin
      shift_q <= {rx_sync, shift_q[8:1]};
    end
  end

  always_ff @(posedge clk) begin
    if (state == RX_STOP && tick && rx_sync) begin
      read_data <= {parity_err, shift_q[7:0]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= RX_IDLE;
      bit_cnt  <= '0;
      read_rdy <= 1'b0;
    end else begin
      read_rdy <= 1'b0;
      case (state)
        RX_IDLE: begin
          // a falling edge, so a line held low after a bad stop bit waits.
          if (!rx_sync && rx_prev) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (tick) begin
            if (!rx_sync) begin
              state   <= RX_BITS;
              bit_cnt <= '0;
            end else begin
              state <= RX_IDLE;  // high at mid start bit, a glitch.
            end
          end
        end
        RX_BITS: begin
          if (tick) begin
            bit_cnt <= bit_cnt + bit_cnt_t'(1);
            if (bit_cnt == PARITY_IDX) begin
              state <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (tick) begin
            read_rdy <= rx_sync;  // framing error drops the byte.
            state    <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  a_read_rdy_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy
  );

endmodule

//--- rtl/cmd_ctrl_fsm.sv
module cmd_ctrl_fsm
  import uart_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  uart_cmd_t cmd_in,
  input  logic      cmd_vld,
  output logic      cmd_rdy,
  uart_tx_if.ctrl   txc
);

  ctrl_state_t state;
  uart_cmd_t   cmd_q;
  logic        accept;

  assign accept = cmd_vld && cmd_rdy;

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
  end

  // the shifter takes data in the load cycle, so it follows the state.
  assign txc.data = (state == SEND_LO) ? cmd_q[7:0] : cmd_q[15:8];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      cmd_rdy  <= 1'b1;
      txc.load <= 1'b0;
    end else begin
      txc.load <= 1'b0;
      case (state)
        IDLE: begin
          if (accept) begin
            state    <= SEND_HI;
            cmd_rdy  <= 1'b0;
            txc.load <= 1'b1;
          end
        end
        SEND_HI: begin
          if (txc.done) begin
            state    <= SEND_LO;
            txc.load <= 1'b1;  // busy has already dropped with done.
          end
        end
        SEND_LO: begin
          if (txc.done) begin
            state   <= IDLE;
            cmd_rdy <= 1'b1;
          end
        end
        default: begin
          state   <= IDLE;
          cmd_rdy <= 1'b1;
        end
      endcase
    end
  end

  a_rdy_only_idle: assert property (
    @(posedge clk) disable iff (!rst_n) (state != IDLE) |-> !cmd_rdy
  );

endmodule

//--- rtl/uart_cmd_top.sv
module uart_cmd_top
  import uart_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [$bits(uart_cmd_t)-1:0]  cmd_in,
  input  logic                          cmd_vld,
  output logic                          cmd_rdy,
  input  logic                          rx,
  output logic                          tx,
  output logic                          read_rdy,
  output logic [$bits(uart_read_t)-1:0] read_data
);

  logic tx_tick;
  logic tx_run;
  logic rx_tick;
  logic rx_run;
  logic rx_half;

  uart_tx_if u_tx_if ();

  cmd_ctrl_fsm u_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_in  (cmd_in),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .txc     (u_tx_if.ctrl)
  );

  uart_tx_shifter u_tx_shifter (
    .clk       (clk),
    .rst_n     (rst_n),
    .txi       (u_tx_if.shifter),
    .tick      (tx_tick),
    .timer_run (tx_run),
    .tx        (tx)
  );

  // transmit bits start on a period boundary.
  baud_timer u_tx_timer (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (tx_run),
    .half  (1'b0),
    .tick  (tx_tick)
  );

  uart_rx_sampler u_rx_sampler (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx),
    .tick       (rx_tick),
    .timer_run  (rx_run),
    .timer_half (rx_half),
    .read_rdy   (read_rdy),
    .read_data  (read_data)
  );

  baud_timer u_rx_timer (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (rx_run),
    .half  (rx_half),
    .tick  (rx_tick)
  );

endmodule

//--- dv/uart_cmd_tb.sv
`include "uart_params.svh"

module uart_cmd_tb;

  localparam int BIT_CYCLES = `UART_CLKS_PER_BIT;
  localparam int NUM_CMDS   = 10;  // eight random ones and two under back-pressure.
  localparam int NUM_INJ    = 3;
  localparam int TIMEOUT_CYCLES = 2 * (NUM_CMDS * 24 + NUM_INJ * 13) * BIT_CYCLES;

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        rx;
  logic        tx;
  logic        read_rdy;
  logic [8:0]  read_data;

  logic        loopback;  // rx follows tx while this is set.
  logic        inj_line;
  integer      seed;
  int          cycle_cnt = 0;
  int          cmds_accepted = 0;
  int          frames_seen = 0;
  logic [7:0]  tx_exp[$];
  logic [8:0]  rx_exp[$];  // parity error flag on top of the byte.

  assign rx = loopback ? tx : inj_line;

  uart_cmd_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  always #4 clk = ~clk;

  task automatic flag_mismatch(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    $display("Errors found");
    $fatal(1, "stopped at the first failed check");
  endtask

  task automatic flag_failure(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("Errors found");
    $fatal(1, "stopped at the first failure");
  endtask

  function automatic logic [15:0] rand_word();
    integer r;
    r = $random(seed);
    return r[15:0];
  endfunction

  function automatic int rand_gap();
    integer r;
    r = $random(seed);
    return r & 3;
  endfunction

  // bits holds start, data, parity and the first sample of the stop bit.
  task automatic check_frame(input logic [10:0] bits);
    logic [7:0] exp_byte;
    assert (bits[0] == 1'b0) else flag_mismatch("start bit on tx is not 0");
    assert (bits[10] == 1'b1) else flag_mismatch("stop bit on tx is not 1");
    assert (^bits[9:1] == 1'b1)
      else flag_mismatch($sformatf("parity bit %b is not odd for byte %02h", bits[9], bits[8:1]));
    assert (tx_exp.size() != 0) else flag_failure("frame on tx with no command byte pending");
    exp_byte = tx_exp.pop_front();
    assert (bits[8:1] == exp_byte)
      else flag_mismatch($sformatf("tx byte %02h, expected %02h", bits[8:1], exp_byte));
    if (loopback) begin
      rx_exp.push_back({1'b0, exp_byte});
    end
  endtask

  // called at the negedge of the first cycle of the start bit.
  task automatic decode_frame();
    logic [10:0] bits;
    for (int b = 0; b < 11; b++) begin
      for (int c = 0; c < BIT_CYCLES; c++) begin
        if (b != 0 || c != 0) begin
          @(negedge clk);
        end
        if (c == 0) begin
          bits[b] = tx;
        end else begin
          assert (tx == bits[b])
            else flag_mismatch($sformatf("tx bit %0d not held for a full bit period", b));
        end
        if (b == 10 && c == 0) begin
          check_frame(bits);
        end
      end
    end
    frames_seen++;
  endtask

  initial begin : tx_decoder
    logic prev;
    prev = 1'b1;
    forever begin
      @(negedge clk);
      if (rst_n && prev && !tx) begin
        decode_frame();
        prev = 1'b1;
      end else begin
        prev = tx;
      end
    end
  end

  // cmd_rdy only moves on posedge, so this sees the value of the next accepting edge.
  always @(negedge clk) begin : accept_monitor
    if (rst_n && cmd_vld && cmd_rdy) begin
      assert (frames_seen == 2 * cmds_accepted)
        else flag_mismatch($sformatf("command accepted after %0d frames, expected %0d",
                                     frames_seen, 2 * cmds_accepted));
      tx_exp.push_back(cmd_in[15:8]);
      tx_exp.push_back(cmd_in[7:0]);
      cmds_accepted++;
    end
  end

  always @(negedge clk) begin : read_monitor
    logic [8:0] exp_word;
    if (rst_n && read_rdy) begin
      assert (rx_exp.size() != 0) else flag_failure("read_rdy pulsed with no byte expected");
      exp_word = rx_exp.pop_front();
      assert (read_data == exp_word)
        else flag_mismatch($sformatf("read_data %03h, expected %03h", read_data, exp_word));
    end
  end

  a_idle_while_ready: assert property (
    @(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx
  ) else flag_mismatch("tx low while cmd_rdy is high");

  a_start_after_accept: assert property (
    @(posedge clk) disable iff (!rst_n) (cmd_vld && cmd_rdy) |=> tx ##1 !tx
  ) else flag_mismatch("start bit not two cycles after the command was accepted");

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      flag_failure($sformatf("timeout, the test did not end within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  task automatic send_cmd(input logic [15:0] c);
    int target;
    target = cmds_accepted + 1;
    @(posedge clk);
    cmd_in  <= c;
    cmd_vld <= 1'b1;
    do begin
      @(posedge clk);
    end while (cmds_accepted < target);
    cmd_vld <= 1'b0;
  endtask

  // cmd_vld stays high across two accepts while cmd_in changes every cycle.
  task automatic hold_valid_while_busy();
    int target;
    target = cmds_accepted + 2;
    @(posedge clk);
    cmd_vld <= 1'b1;
    cmd_in  <= rand_word();
    do begin
      @(posedge clk);
      cmd_in <= rand_word();
    end while (cmds_accepted < target);
    cmd_vld <= 1'b0;
  endtask

  task automatic inject_frame(input logic [7:0] b, input bit bad_parity, input bit bad_stop);
    logic [10:0] f;
    f = {~bad_stop, (~^b) ^ bad_parity, b, 1'b0};
    if (!bad_stop) begin
      rx_exp.push_back({bad_parity && (`UART_PARITY_CHECK != 0), b});
    end
    for (int i = 0; i < 11; i++) begin
      repeat (BIT_CYCLES) begin
        @(posedge clk);
        inj_line <= f[i];
      end
    end
    @(posedge clk);
    inj_line <= 1'b1;
    repeat (2 * BIT_CYCLES) @(posedge clk);
  endtask

  task automatic wait_drained();
    @(negedge clk);
    while (!cmd_rdy || tx_exp.size() != 0 || rx_exp.size() != 0) begin
      @(negedge clk);
    end
    repeat (2 * BIT_CYCLES) @(posedge clk);
  endtask

  initial begin : main_seq
    logic [15:0] w;
    seed     = 32'h698f;
    clk      = 1'b0;
    rst_n    = 1'b0;
    cmd_in   = '0;
    cmd_vld  = 1'b0;
    loopback = 1'b1;
    inj_line = 1'b1;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (tx == 1'b1 && cmd_rdy == 1'b1 && read_rdy == 1'b0)
      else flag_mismatch($sformatf("after reset tx=%b cmd_rdy=%b read_rdy=%b",
                                   tx, cmd_rdy, read_rdy));
    repeat (BIT_CYCLES) @(posedge clk);

    for (int i = 0; i < 8; i++) begin
      send_cmd(rand_word());
      repeat (rand_gap()) @(posedge clk);
    end
    wait_drained();

    hold_valid_while_busy();
    wait_drained();

    @(posedge clk);
    loopback <= 1'b0;
    w = rand_word();
    inject_frame(w[7:0], 1'b1, 1'b0);
    inject_frame(w[15:8], 1'b0, 1'b1);
    w = rand_word();
    inject_frame(w[7:0], 1'b0, 1'b0);
    wait_drained();

    if (cmds_accepted == NUM_CMDS && frames_seen == 2 * cmds_accepted) begin
      $display("No errors");
      $finish;
    end else begin
      flag_mismatch($sformatf("%0d commands and %0d frames seen, expected %0d and %0d",
                              cmds_accepted, frames_seen, NUM_CMDS, 2 * NUM_CMDS));
    end
  end

endmodule

//--- tb.f
+incdir+rtl
rtl/uart_pkg.sv
rtl/uart_tx_if.sv
rtl/baud_timer.sv
rtl/uart_tx_shifter.sv
rtl/uart_rx_sampler.sv
rtl/cmd_ctrl_fsm.sv
rtl/uart_cmd_top.sv
dv/uart_cmd_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f tb.f \
  --top-module uart_cmd_tb \
  -Mdir obj_dir \
  -o uart_cmd_sim

./obj_dir/uart_cmd_sim
